//--- verilog/md_cfg.svh
`ifndef MD_CFG_SVH
`define MD_CFG_SVH

// ------------------------------
// datapath sizing
// ------------------------------

// operand / result width (rv32)
`define MD_XLEN 32

// ------------------------------
// tag sizing
// ------------------------------

`define MD_ROB_W 5     // rob entries = 32
`define MD_PHY_W 6     // physical regs = 64

// ------------------------------
// multiplier throughput
// ------------------------------

// multiplier bits consumed per cycle, 2 -> radix 4
`define MD_MUL_RADIX_BITS 2

`endif

//--- verilog/md_pkg.sv
`include "md_cfg.svh"

package md_pkg;

    // ------------------------------
    // opcodes
    // ------------------------------

    // bit 2 splits multiplies from divides
    typedef enum logic [2:0] {
        MD_MUL    = 3'd0,   // low word, sign irrelevant
        MD_MULH   = 3'd1,   // high word, s x s
        MD_MULHSU = 3'd2,   // high word, s x u
        MD_MULHU  = 3'd3,   // high word, u x u
        MD_DIV    = 3'd4,
        MD_DIVU   = 3'd5,
        MD_REM    = 3'd6,
        MD_REMU   = 3'd7
    } md_op_e;

    // ------------------------------
    // unit fsm, shared by mul and div
    // ------------------------------

    typedef enum logic [1:0] {
        IDLE = 2'd0,    // free for a new op
        BUSY = 2'd1,    // iterating
        DONE = 2'd2     // result parked, waiting for grant
    } unit_state_e;

    // ------------------------------
    // payloads
    // ------------------------------

    // request from the reservation station, 78 bits
    typedef struct packed {
        md_op_e                 op;
        logic [`MD_XLEN-1:0]    rs1_value;
        logic [`MD_XLEN-1:0]    rs2_value;
        logic [`MD_ROB_W-1:0]   rob_id;
        logic [`MD_PHY_W-1:0]   rd_phy;
    } md_req_t;

    // common data bus beat, 44 bits
    typedef struct packed {
        logic                   valid;
        logic [`MD_ROB_W-1:0]   rob_id;
        logic [`MD_PHY_W-1:0]   rd_phy;
        logic [`MD_XLEN-1:0]    rd_value;
    } cdb_t;

    // finished result, unit -> arbiter, 43 bits
    typedef struct packed {
        logic [`MD_ROB_W-1:0]   rob_id;
        logic [`MD_PHY_W-1:0]   rd_phy;
        logic [`MD_XLEN-1:0]    rd_value;
    } unit_res_t;

endpackage

//--- verilog/md_issue.sv
module md_issue
import md_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // four-phase slave side
    input  logic        req,
    input  md_req_t     op_in,
    output logic        ack,

    // unit side
    input  logic        mul_busy,
    input  logic        div_busy,
    output logic        mul_start,
    output logic        div_start,
    output md_req_t     op_reg
);

    // ------------------------------
    // decode
    // ------------------------------

    logic target_div;       // opcode goes to the divider
    logic target_busy;      // selected unit can't take it yet
    logic accept;           // take op_in on this edge

    assign target_div  = op_in.op inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU};
    assign target_busy = target_div ? div_busy : mul_busy;

    // only from the ack-low phase; a busy target holds ack back
    assign accept = req && !ack && !target_busy;

    // ------------------------------
    // handshake fsm
    // ------------------------------

    // ack is the state bit: low = waiting for req, high = waiting for req to drop
    always_ff @(posedge clk) begin
        if (rst) begin
            ack       <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= accept && !target_div;     // one cycle only
            div_start <= accept && target_div;
            if (accept) begin
                ack <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;                        // return to zero
            end
        end
    end

    // operand latch, valid alongside the start pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            op_reg <= op_in;
        end
    end

    // ------------------------------
    // checks
    // ------------------------------

    // requester must still be asserting when we answer
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req));

    // unit busy flags come back from the other modules
    a_mul_start_free: assert property (@(posedge clk) disable iff (rst)
        mul_start |-> !mul_busy);
    a_div_start_free: assert property (@(posedge clk) disable iff (rst)
        div_start |-> !div_busy);

endmodule

//--- verilog/seq_mul.sv
`include "md_cfg.svh"

module seq_mul
import md_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        start,
    input  md_req_t     op,
    input  logic        grant,

    output logic        busy,
    output logic        done,
    output unit_res_t   res
);

    localparam int XLEN  = `MD_XLEN;
    localparam int RB    = `MD_MUL_RADIX_BITS;
    localparam int ITERS = (XLEN + RB) / RB;    // digits covering XLEN+1 bits
    localparam int MW    = ITERS * RB;          // padded multiplier width
    localparam int PW    = 2 * XLEN;            // product width kept
    localparam int CW    = $clog2(ITERS);

    unit_state_e        state;
    logic [CW-1:0]      cnt;        // digits left after this one
    logic [PW-1:0]      mcand;      // shifts left each step
    logic [MW-1:0]      mplier;     // shifts right each step
    logic [PW-1:0]      acc;
    logic               hi_sel;     // take upper word
    unit_res_t          res_q;

    logic               rs1_signed, rs2_signed;
    logic [XLEN:0]      a_ext, b_ext;   // 33-bit extended operands
    logic               last_digit;
    logic [PW-1:0]      pp;             // partial product of this digit
    logic [PW-1:0]      acc_next;

    // ------------------------------
    // operand extension
    // ------------------------------

    assign rs1_signed = op.op inside {MD_MUL, MD_MULH, MD_MULHSU};
    assign rs2_signed = op.op inside {MD_MUL, MD_MULH};
    assign a_ext = {rs1_signed & op.rs1_value[XLEN-1], op.rs1_value};
    assign b_ext = {rs2_signed & op.rs2_value[XLEN-1], op.rs2_value};

    // ------------------------------
    // digit step
    // ------------------------------

    assign last_digit = (cnt == '0);

    // top bit of the last digit is the two's complement sign, negative weight
    always_comb begin
        pp = '0;
        for (int j = 0; j < RB; j++) begin
            if (mplier[j]) begin
                if (last_digit && j == RB - 1) begin
                    pp = pp - (mcand << j);
                end else begin
                    pp = pp + (mcand << j);
                end
            end
        end
    end

    assign acc_next = acc + pp;     // mod 2^64 is all we need

    // ------------------------------
    // control
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state <= BUSY;
                    cnt   <= CW'(ITERS - 1);
                end
                BUSY: begin
                    cnt <= cnt - 1'b1;
                    if (last_digit) state <= DONE;
                end
                DONE: if (grant) state <= IDLE;    // free next cycle
                default: state <= IDLE;
            endcase
        end
    end

    // ------------------------------
    // datapath
    // ------------------------------

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            mcand        <= PW'($signed(a_ext));
            mplier       <= MW'($signed(b_ext));
            acc          <= '0;
            hi_sel       <= (op.op != MD_MUL);
            res_q.rob_id <= op.rob_id;
            res_q.rd_phy <= op.rd_phy;
        end else if (state == BUSY) begin
            acc    <= acc_next;
            mcand  <= mcand << RB;
            mplier <= mplier >> RB;
            if (last_digit) begin
                res_q.rd_value <= hi_sel ? acc_next[PW-1:XLEN] : acc_next[XLEN-1:0];
            end
        end
    end

    assign busy = (state != IDLE);
    assign done = (state == DONE);
    assign res  = res_q;                // steady while parked in DONE

endmodule

//--- verilog/seq_div.sv
`include "md_cfg.svh"

module seq_div
import md_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        start,
    input  md_req_t     op,
    input  logic        grant,

    output logic        busy,
    output logic        done,
    output unit_res_t   res
);

    localparam int XLEN = `MD_XLEN;
    localparam int CW   = $clog2(XLEN + 1);

    unit_state_e        state;
    logic [CW-1:0]      cnt;        // shift steps remaining, 0 = fix-up
    logic [XLEN-1:0]    dvsr;       // |divisor|
    logic [XLEN-1:0]    quo;        // dividend shifts out, quotient shifts in
    logic [XLEN-1:0]    rem;        // partial remainder
    logic               is_rem;
    logic               neg_q;      // quotient sign
    logic               neg_r;      // remainder follows dividend
    unit_res_t          res_q;

    logic               signed_op, rem_op;
    logic               a_neg, b_neg;
    logic [XLEN-1:0]    a_mag, b_mag;
    logic               div_zero;
    logic [XLEN:0]      shifted;    // remainder with next dividend bit
    logic [XLEN:0]      diff;       // trial subtract

    // ------------------------------
    // operand prep
    // ------------------------------

    assign signed_op = op.op inside {MD_DIV, MD_REM};
    assign rem_op    = op.op inside {MD_REM, MD_REMU};
    assign a_neg     = signed_op & op.rs1_value[XLEN-1];
    assign b_neg     = signed_op & op.rs2_value[XLEN-1];
    assign a_mag     = a_neg ? -op.rs1_value : op.rs1_value;
    assign b_mag     = b_neg ? -op.rs2_value : op.rs2_value;
    assign div_zero  = (op.rs2_value == '0);

    // ------------------------------
    // restoring step
    // ------------------------------

    assign shifted = {rem, quo[XLEN-1]};
    assign diff    = shifted - {1'b0, dvsr};    // msb set -> restore

    // ------------------------------
    // control
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    // zero divisor skips the loop, answer is fixed
                    state <= div_zero ? DONE : BUSY;
                    cnt   <= CW'(XLEN);
                end
                BUSY: begin
                    if (cnt == '0) begin
                        state <= DONE;          // fix-up edge
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                DONE: if (grant) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // ------------------------------
    // datapath
    // ------------------------------

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            dvsr         <= b_mag;
            quo          <= a_mag;
            rem          <= '0;
            is_rem       <= rem_op;
            neg_q        <= a_neg ^ b_neg;
            neg_r        <= a_neg;
            res_q.rob_id <= op.rob_id;
            res_q.rd_phy <= op.rd_phy;
            // x/0: q = all ones, r = dividend
            if (div_zero) res_q.rd_value <= rem_op ? op.rs1_value : '1;
        end else if (state == BUSY) begin
            if (cnt != '0) begin
                if (!diff[XLEN]) begin
                    rem <= diff[XLEN-1:0];
                    quo <= {quo[XLEN-2:0], 1'b1};
                end else begin
                    rem <= shifted[XLEN-1:0];
                    quo <= {quo[XLEN-2:0], 1'b0};
                end
            end else begin
                // sign fix-up; min_int / -1 wraps back to min_int with r = 0
                if (is_rem) begin
                    res_q.rd_value <= neg_r ? -rem : rem;
                end else begin
                    res_q.rd_value <= neg_q ? -quo : quo;
                end
            end
        end
    end

    assign busy = (state != IDLE);
    assign done = (state == DONE);
    assign res  = res_q;

    // issue must never restart an op that is still in flight
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

//--- verilog/cdb_arbiter.sv
module cdb_arbiter
import md_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        mul_done,
    input  logic        div_done,
    input  unit_res_t   mul_res,
    input  unit_res_t   div_res,

    output logic        mul_grant,
    output logic        div_grant,
    output cdb_t        cdb
);

    unit_res_t sel_res;     // winner's payload

    // ------------------------------
    // fixed priority, mul first
    // ------------------------------

    assign mul_grant = mul_done;
    assign div_grant = div_done && !mul_done;
    assign sel_res   = mul_grant ? mul_res : div_res;

    // ------------------------------
    // cdb register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= mul_grant || div_grant;    // one beat per grant
        end
    end

    always_ff @(posedge clk) begin
        if (mul_grant || div_grant) begin
            cdb.rob_id   <= sel_res.rob_id;
            cdb.rd_phy   <= sel_res.rd_phy;
            cdb.rd_value <= sel_res.rd_value;
        end
    end

    // ------------------------------
    // checks
    // ------------------------------

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(mul_grant && div_grant));

    // a granted unit must drop done next cycle, else the result goes out twice
    a_mul_release: assert property (@(posedge clk) disable iff (rst)
        mul_grant |=> !mul_done);
    a_div_release: assert property (@(posedge clk) disable iff (rst)
        div_grant |=> !div_done);

endmodule

//--- verilog/md_unit.sv
module md_unit
import md_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        req,
    input  md_req_t     op_in,
    output logic        ack,

    output cdb_t        cdb
);

    // issue <-> units
    logic       mul_start, div_start;
    logic       mul_busy, div_busy;
    md_req_t    op_reg;             // shared, only the started unit latches it

    // units <-> arbiter
    logic       mul_done, div_done;
    logic       mul_grant, div_grant;
    unit_res_t  mul_res, div_res;

    md_issue u_issue (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .op_in     (op_in),
        .ack       (ack),
        .mul_busy  (mul_busy),
        .div_busy  (div_busy),
        .mul_start (mul_start),
        .div_start (div_start),
        .op_reg    (op_reg)
    );

    seq_mul u_mul (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .op    (op_reg),
        .grant (mul_grant),
        .busy  (mul_busy),
        .done  (mul_done),
        .res   (mul_res)
    );

    seq_div u_div (
        .clk   (clk),
        .rst   (rst),
        .start (div_start),
        .op    (op_reg),
        .grant (div_grant),
        .busy  (div_busy),
        .done  (div_done),
        .res   (div_res)
    );

    cdb_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .mul_done  (mul_done),
        .div_done  (div_done),
        .mul_res   (mul_res),
        .div_res   (div_res),
        .mul_grant (mul_grant),
        .div_grant (div_grant),
        .cdb       (cdb)
    );

endmodule

//--- testbench/md_ref_pkg.sv
`include "md_cfg.svh"

package md_ref_pkg;

    import md_pkg::*;

    localparam int XLEN = `MD_XLEN;

    // ------------------------------
    // multiply
    // ------------------------------

    // full 2*xlen product, then pick a word
    function automatic logic [XLEN-1:0] ref_mul(input md_op_e op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] a_wide;
        logic [2*XLEN-1:0] b_wide;
        logic [2*XLEN-1:0] prod;
        logic              a_signed;
        logic              b_signed;
        a_signed = (op == MD_MULH) || (op == MD_MULHSU);   // mul low word ignores sign
        b_signed = (op == MD_MULH);
        a_wide   = a_signed ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        b_wide   = b_signed ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        prod     = a_wide * b_wide;     // mod 2^64 keeps the signed product intact
        return (op == MD_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    endfunction

    // ------------------------------
    // divide / remainder
    // ------------------------------

    function automatic logic [XLEN-1:0] ref_div(input md_op_e op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [XLEN-1:0] min_int;
        logic            want_rem;
        logic            signed_op;
        min_int   = {1'b1, {(XLEN-1){1'b0}}};
        want_rem  = (op == MD_REM) || (op == MD_REMU);
        signed_op = (op == MD_DIV) || (op == MD_REM);
        if (b == '0) begin
            return want_rem ? a : '1;               // riscv x/0 rule
        end
        if (signed_op && a == min_int && b == '1) begin
            return want_rem ? '0 : min_int;         // overflow case
        end
        if (signed_op) begin
            // sv truncates toward zero, remainder takes dividend sign
            return want_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
        end
        return want_rem ? a % b : a / b;
    endfunction

    // expected cdb beat for one request
    function automatic cdb_t ref_cdb(input md_req_t r);
        cdb_t c;
        c.valid  = 1'b1;
        c.rob_id = r.rob_id;
        c.rd_phy = r.rd_phy;
        if (r.op inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU}) begin
            c.rd_value = ref_div(r.op, r.rs1_value, r.rs2_value);
        end else begin
            c.rd_value = ref_mul(r.op, r.rs1_value, r.rs2_value);
        end
        return c;
    endfunction

endpackage

//--- testbench/md_tb.sv
`include "md_cfg.svh"

module md_tb
import md_pkg::*;
import md_ref_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROBS        = 1 << `MD_ROB_W;
    localparam int MUL_CYCLES  = `MD_XLEN / `MD_MUL_RADIX_BITS + 1;    // start to done
    localparam int DIV_CYCLES  = `MD_XLEN + 1;
    localparam int ACK_TIMEOUT = 200;
    localparam int CDB_TIMEOUT = 400;

    logic       clk;
    logic       rst;
    logic       req;
    md_req_t    op_in;
    logic       ack;
    cdb_t       cdb;

    integer     seed = 85766;

    // scoreboard indexed by rob id
    cdb_t       exp_tab   [ROBS];
    string      name_tab  [ROBS];
    bit         pending   [ROBS];
    int         order_tab [ROBS];   // issue sequence number
    int         n_issued;
    int         n_out_of_order;
    logic [`MD_ROB_W-1:0] next_rob;

    md_unit dut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .op_in (op_in),
        .ack   (ack),
        .cdb   (cdb)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;           // 4 ns period

    // ------------------------------
    // reporting and compares
    // ------------------------------

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_cdb(input string name, input cdb_t exp, input cdb_t act);
        if (act !== exp) begin
            stop_run($sformatf(
                "[ERROR] %s expected rob %0d phy %0d value %h actual rob %0d phy %0d value %h",
                name, exp.rob_id, exp.rd_phy, exp.rd_value,
                act.rob_id, act.rd_phy, act.rd_value));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
        end
    endtask

    // cycles from req rise to ack seen high
    task automatic check_wait(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_run($sformatf("[ERROR] %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    function automatic bit any_pending();
        for (int i = 0; i < ROBS; i++) begin
            if (pending[i]) return 1'b1;
        end
        return 1'b0;
    endfunction

    // operand mix with the awkward values showing up often
    function automatic logic [`MD_XLEN-1:0] rand_operand();
        case ($random(seed) & 7)
            0:       return '0;
            1:       return {1'b1, {(`MD_XLEN-1){1'b0}}};  // most negative
            2:       return '1;                            // -1
            3:       return $random(seed) & 32'hff;        // small
            default: return $random(seed);
        endcase
    endfunction

    // ------------------------------
    // cdb monitor
    // ------------------------------

    task automatic take_result(input cdb_t act);
        int id;
        bit older;
        id    = int'(act.rob_id);
        older = 1'b0;
        if (!pending[id]) begin
            stop_run($sformatf("CDB carried rob id %0d with no operation outstanding", id));
        end else begin
            for (int i = 0; i < ROBS; i++) begin
                if (pending[i] && order_tab[i] < order_tab[id]) older = 1'b1;
            end
            if (older) n_out_of_order++;    // an earlier op is still out
            check_cdb(name_tab[id], exp_tab[id], act);
            pending[id] = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && cdb.valid === 1'b1) begin
            take_result(cdb);
        end
    end

    // ------------------------------
    // four-phase master
    // ------------------------------

    task automatic issue_op(input md_op_e op, input logic [`MD_XLEN-1:0] a,
                            input logic [`MD_XLEN-1:0] b, input string name,
                            output int ack_wait);
        md_req_t     r;
        int          id;
        int          cnt;
        logic [95:0] junk;
        r.op        = op;
        r.rs1_value = a;
        r.rs2_value = b;
        r.rob_id    = next_rob;
        r.rd_phy    = 6'($random(seed));
        id          = int'(next_rob);
        next_rob    = next_rob + 1'b1;
        cnt = 0;
        while (pending[id]) begin           // rob slot still in flight
            @(negedge clk);
            cnt++;
            if (cnt > CDB_TIMEOUT) stop_run($sformatf("%s: rob id %0d never retired", name, id));
        end
        exp_tab[id]   = ref_cdb(r);
        name_tab[id]  = $sformatf("%s %s", name, op.name());
        order_tab[id] = n_issued;
        pending[id]   = 1'b1;
        n_issued++;
        op_in = r;
        req   = 1'b1;
        ack_wait = 0;
        while (ack !== 1'b1) begin
            @(negedge clk);
            ack_wait++;
            if (ack_wait > ACK_TIMEOUT) stop_run($sformatf("%s: ack never rose", name));
        end
        req  = 1'b0;
        junk = {$random(seed), $random(seed), $random(seed)};
        op_in = junk[$bits(md_req_t)-1:0];  // bus is don't-care once req drops
        cnt = 0;
        while (ack !== 1'b0) begin
            @(negedge clk);
            cnt++;
            if (cnt > ACK_TIMEOUT) begin
                stop_run($sformatf("%s: ack never fell after req dropped", name));
            end
        end
    endtask

    task automatic drain(input string name);
        int cnt;
        cnt = 0;
        while (any_pending()) begin
            @(negedge clk);
            cnt++;
            if (cnt > CDB_TIMEOUT) stop_run($sformatf("%s: results missing on the CDB", name));
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------

    initial begin
        int     w;
        int     w2;
        md_op_e op;
        rst      = 1'b1;
        req      = 1'b0;
        op_in    = '0;
        next_rob = '0;

        // reset state
        repeat (8) begin
            @(negedge clk);
            check_bit("reset ack", 1'b0, ack);
            check_bit("reset cdb valid", 1'b0, cdb.valid);
        end
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_bit("post reset ack", 1'b0, ack);
            check_bit("post reset cdb valid", 1'b0, cdb.valid);
        end

        // random multiplies
        for (int i = 0; i < 40; i++) begin
            op = md_op_e'(3'($random(seed) & 3));
            issue_op(op, $random(seed), $random(seed), "mul_random", w);
        end
        drain("mul_random");

        // random divides with divisor magnitude varied by shifting
        for (int i = 0; i < 40; i++) begin
            op = md_op_e'(3'(4 + ($random(seed) & 3)));
            issue_op(op, $random(seed), $random(seed) >>> ($random(seed) & 31), "div_random", w);
        end
        drain("div_random");

        // x/0 and min_int / -1
        for (int k = 4; k < 8; k++) begin
            op = md_op_e'(3'(k));
            issue_op(op, $random(seed), '0, "div_by_zero", w);
            issue_op(op, {1'b1, {(`MD_XLEN-1){1'b0}}}, '1, "div_overflow", w);
        end
        drain("div_corner");

        // mixed stream where some results should return out of order
        n_out_of_order = 0;
        for (int i = 0; i < 100; i++) begin
            op = md_op_e'(3'($random(seed)));
            issue_op(op, rand_operand(), rand_operand(), "mixed", w);
        end
        drain("mixed");
        if (n_out_of_order == 0) stop_run("mixed: no result came back out of order");

        // same unit back to back so the second ack waits for the first op
        issue_op(MD_MULHU, $random(seed), $random(seed), "busy_mul first", w);
        check_wait("busy_mul first ack wait", 1, w);   // both units idle after drain
        issue_op(MD_MUL, $random(seed), $random(seed), "busy_mul second", w2);
        if (w2 < MUL_CYCLES) begin
            stop_run($sformatf("busy_mul: second ack after %0d cycles, multiplier still busy",
                               w2));
        end
        drain("busy_mul");
        issue_op(MD_DIV, $random(seed), 32'd7, "busy_div first", w);
        check_wait("busy_div first ack wait", 1, w);
        issue_op(MD_REMU, $random(seed), 32'd9, "busy_div second", w2);
        if (w2 < DIV_CYCLES) begin
            stop_run($sformatf("busy_div: second ack after %0d cycles, divider still busy",
                               w2));
        end
        // free multiplier must answer right away while div runs
        issue_op(MD_MULH, $random(seed), $random(seed), "side_by_side", w2);
        check_wait("side_by_side ack wait", 1, w2);
        drain("busy_unit");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/md_pkg.sv
verilog/md_issue.sv
verilog/seq_mul.sv
verilog/seq_div.sv
verilog/cdb_arbiter.sv
verilog/md_unit.sv
testbench/md_ref_pkg.sv
testbench/md_tb.sv

//--- Bender.yml
package:
  name: md_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/md_pkg.sv
      - verilog/md_issue.sv
      - verilog/seq_mul.sv
      - verilog/seq_div.sv
      - verilog/cdb_arbiter.sv
      - verilog/md_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/md_ref_pkg.sv
      - testbench/md_tb.sv
